// ==== compile.f ====
mdu_arith_pkg.sv
mdu_types_pkg.sv
mul_seq16.sv
div_seq16.sv
mdu_dispatch.sv
mdu_top.sv
mdu_sva.sv
mdu_checker.sv
mdu_tb.sv

// ==== div_seq16.sv ====
/*
 * Sequential 16-bit restoring divider.
 * One shift-subtract step per cycle on the magnitudes; quotient and
 * remainder signs, divide by zero and signed overflow are settled last.
 */
module div_seq16
(
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    start,
   input  logic                                    is_signed,
   input  logic [mdu_arith_pkg::OPERAND_WIDTH-1:0] dividend,
   input  logic [mdu_arith_pkg::OPERAND_WIDTH-1:0] divisor,
   output logic                                    done,
   output logic [mdu_arith_pkg::OPERAND_WIDTH-1:0] quotient,
   output logic [mdu_arith_pkg::OPERAND_WIDTH-1:0] remainder
);

   import mdu_arith_pkg::*;

   unit_state_t              state;
   logic [STEP_WIDTH-1:0]    step;

   logic                     signed_q;
   logic [OPERAND_WIDTH-1:0] dividend_raw;
   logic [OPERAND_WIDTH-1:0] divisor_raw;
   logic [OPERAND_WIDTH-1:0] dq;
   logic [OPERAND_WIDTH-1:0] dv_mag;
   logic [OPERAND_WIDTH-1:0] rem;
   logic                     neg_quot;
   logic                     neg_rem;
   logic                     div_zero;
   logic                     overflow;

   logic [OPERAND_WIDTH:0]   partial;
   logic [OPERAND_WIDTH:0]   diff;
   logic                     fits;

   // next dividend bit shifted into the partial remainder.
   assign partial = {rem, dq[OPERAND_WIDTH-1]};
   assign diff    = partial - {1'b0, dv_mag};
   assign fits    = (partial >= {1'b0, dv_mag});

   assign done = (state == UNIT_LAST);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= UNIT_IDLE;
         step  <= '0;
      end
      else
      begin
         case (state)
            UNIT_IDLE:
            begin
               if (start)
               begin
                  state <= UNIT_RUNNING;
                  step  <= LOAD_STEP;
               end
            end
            UNIT_RUNNING:
            begin
               if (step == FINAL_STEP)
               begin
                  state <= UNIT_LAST;
               end
               step <= step + 1'b1;
            end
            default:
            begin
               state <= UNIT_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == UNIT_IDLE)
      begin
         if (start)
         begin
            dividend_raw <= dividend;
            divisor_raw  <= divisor;
            signed_q     <= is_signed;
         end
      end
      else if (state == UNIT_RUNNING)
      begin
         if (step == LOAD_STEP)
         begin
            dq       <= magnitude(dividend_raw, signed_q);
            dv_mag   <= magnitude(divisor_raw, signed_q);
            rem      <= '0;
            neg_quot <= signed_q & (dividend_raw[OPERAND_WIDTH-1] ^
                                    divisor_raw[OPERAND_WIDTH-1]);
            // remainder follows the dividend sign.
            neg_rem  <= signed_q & dividend_raw[OPERAND_WIDTH-1];
            div_zero <= (divisor_raw == '0);
            overflow <= signed_q & (dividend_raw == MOST_NEGATIVE) & (divisor_raw == '1);
         end
         else if (step == FINAL_STEP)
         begin
            if (div_zero)
            begin
               quotient  <= '1;
               remainder <= dividend_raw;
            end
            else if (overflow)
            begin
               quotient  <= MOST_NEGATIVE;
               remainder <= '0;
            end
            else
            begin
               quotient  <= neg_quot ? -dq : dq;
               remainder <= neg_rem ? -rem : rem;
            end
         end
         else
         begin
            // restore by keeping the partial value when the divisor does not fit.
            rem <= fits ? diff[OPERAND_WIDTH-1:0] : partial[OPERAND_WIDTH-1:0];
            dq  <= {dq[OPERAND_WIDTH-2:0], fits};
         end
      end
   end

endmodule

// ==== mdu_arith_pkg.sv ====
/*
 * Arithmetic constants of the multiply/divide unit.
 * Widths, step counts and the shared unit state encoding.
 */
package mdu_arith_pkg;

   localparam int OPERAND_WIDTH = 16;
   localparam int RESULT_WIDTH  = 2 * OPERAND_WIDTH;
   localparam int ITERATIONS    = OPERAND_WIDTH;

   // the load step, the bit steps and the sign fix step lie between start and done.
   localparam int UNIT_LATENCY  = ITERATIONS + 2;
   localparam int STEP_WIDTH    = $clog2(UNIT_LATENCY);

   localparam logic [STEP_WIDTH-1:0]    LOAD_STEP     = '0;
   localparam logic [STEP_WIDTH-1:0]    FINAL_STEP    = STEP_WIDTH'(ITERATIONS + 1);
   localparam logic [OPERAND_WIDTH-1:0] MOST_NEGATIVE = {1'b1, {(OPERAND_WIDTH - 1){1'b0}}};

   typedef enum logic [1:0]
   {
      UNIT_IDLE    = 2'd0,
      UNIT_RUNNING = 2'd1,
      UNIT_LAST    = 2'd2
   } unit_state_t;

   // magnitude of an operand that is negative only when signed.
   function automatic logic [OPERAND_WIDTH-1:0] magnitude(input logic [OPERAND_WIDTH-1:0] value,
                                                          input logic is_signed);
      return (is_signed && value[OPERAND_WIDTH-1]) ? -value : value;
   endfunction

endpackage

// ==== mdu_checker.sv ====
/*
 * Response checker of the multiply/divide unit testbench.
 * Predicts the result of each accepted request from the arithmetic rules
 * and checks the response timing, the busy level and the value.
 */
module mdu_checker
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     req_valid,
   input  mdu_types_pkg::mdu_req_t  req,
   input  logic                     busy,
   input  logic                     resp_valid,
   input  mdu_types_pkg::mdu_resp_t resp,
   output int                       checked,
   output int                       errors,
   output int                       ignored
);

   import mdu_arith_pkg::*;
   import mdu_types_pkg::*;

   // register stage in dispatch on each side of the unit.
   localparam int RESP_LATENCY = UNIT_LATENCY + 2;

   logic                    pending;
   logic                    reset_seen;
   int                      cycle;
   int                      due_cycle;
   int                      fall_cycle;
   mdu_req_t                pend_req;
   logic [RESULT_WIDTH-1:0] expected;

   function automatic logic [RESULT_WIDTH-1:0] model_result(input mdu_req_t r);
      longint                   a_val;
      longint                   b_val;
      logic [OPERAND_WIDTH-1:0] quot;
      logic [OPERAND_WIDTH-1:0] rmd;
      if (r.is_signed)
      begin
         a_val = $signed(r.a);
         b_val = $signed(r.b);
      end
      else
      begin
         a_val = r.a;
         b_val = r.b;
      end
      if (r.op == MDU_MUL)
         return RESULT_WIDTH'(a_val * b_val);
      if (b_val == 0)
      begin
         quot = '1;
         rmd  = r.a;
      end
      else if (r.is_signed && a_val == -32768 && b_val == -1)
      begin
         quot = OPERAND_WIDTH'(-32768);
         rmd  = '0;
      end
      else
      begin
         // truncating division gives the remainder the sign of the dividend.
         quot = OPERAND_WIDTH'(a_val / b_val);
         rmd  = OPERAND_WIDTH'(a_val % b_val);
      end
      return {rmd, quot};
   endfunction

   task automatic report_failure(input string what);
      $display("ERROR at %0t: %s", $time, what);
      errors = errors + 1;
   endtask

   task automatic check_response();
      logic ok;
      ok = 1'b1;
      if (resp.op !== pend_req.op)
      begin
         $display("MISMATCH at %0t: resp.op expected %0d actual %0d",
                  $time, pend_req.op, resp.op);
         ok = 1'b0;
      end
      if (resp.value !== expected)
      begin
         $display("MISMATCH at %0t: resp.value expected 0x%h actual 0x%h",
                  $time, expected, resp.value);
         ok = 1'b0;
      end
      if (!ok)
         errors = errors + 1;
      checked    = checked + 1;
      pending    = 1'b0;
      fall_cycle = cycle + 1;
      $display("test %0d: %s signed=%0d a=0x%h b=0x%h result=0x%h %s", checked,
               (pend_req.op == MDU_MUL) ? "mul" : "div", pend_req.is_signed,
               pend_req.a, pend_req.b, resp.value, ok ? "ok" : "failed");
   endtask

   // ports are sampled mid-cycle on the falling clock edge.
   always @(negedge clk)
   begin
      if (reset)
      begin
         pending    = 1'b0;
         reset_seen = 1'b0;
         cycle      = 0;
         fall_cycle = -1;
         checked    = 0;
         errors     = 0;
         ignored    = 0;
      end
      else
      begin
         cycle = cycle + 1;
         if (!reset_seen && (busy || resp_valid))
            report_failure("busy or resp_valid is high right after reset");
         reset_seen = 1'b1;
         if (pending && !busy)
            report_failure("busy is low while a request is in flight");
         if (cycle == fall_cycle && busy)
            report_failure("busy did not fall after the response");
         if (resp_valid)
         begin
            if (pending && cycle == due_cycle)
               check_response();
            else
               report_failure("resp_valid is high with no response due");
         end
         else if (pending && cycle >= due_cycle)
         begin
            report_failure("no response at the expected cycle");
            pending = 1'b0;
            checked = checked + 1;
            $display("test %0d: %s signed=%0d a=0x%h b=0x%h no response failed", checked,
                     (pend_req.op == MDU_MUL) ? "mul" : "div", pend_req.is_signed,
                     pend_req.a, pend_req.b);
         end
         // a request seen with busy high must be dropped.
         if (req_valid && busy)
            ignored = ignored + 1;
         else if (req_valid)
         begin
            pending   = 1'b1;
            pend_req  = req;
            expected  = model_result(req);
            due_cycle = cycle + RESP_LATENCY + 1;
         end
      end
   end

endmodule

// ==== mdu_dispatch.sv ====
/*
 * Request dispatch for the multiply/divide unit.
 * Takes one request at a time, starts the matching unit and
 * registers its result as a tagged one-cycle response.
 */
module mdu_dispatch
(
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    req_valid,
   input  mdu_types_pkg::mdu_req_t                 req,
   output logic                                    busy,
   output logic                                    resp_valid,
   output mdu_types_pkg::mdu_resp_t                resp,
   output logic                                    mul_start,
   output logic                                    div_start,
   output logic                                    is_signed,
   output logic [mdu_arith_pkg::OPERAND_WIDTH-1:0] opnd_a,
   output logic [mdu_arith_pkg::OPERAND_WIDTH-1:0] opnd_b,
   input  logic                                    mul_done,
   input  logic [mdu_arith_pkg::RESULT_WIDTH-1:0]  mul_product,
   input  logic                                    div_done,
   input  logic [mdu_arith_pkg::OPERAND_WIDTH-1:0] div_quotient,
   input  logic [mdu_arith_pkg::OPERAND_WIDTH-1:0] div_remainder
);

   import mdu_arith_pkg::*;
   import mdu_types_pkg::*;

   mdu_op_t                 op_q;
   logic                    accept;
   logic                    unit_done;
   logic [RESULT_WIDTH-1:0] unit_value;

   // requests seen while busy are dropped.
   assign accept = req_valid & ~busy;

   // only the unit that was started can finish.
   assign unit_done  = (op_q == MDU_MUL) ? mul_done : div_done;
   assign unit_value = (op_q == MDU_MUL) ? mul_product : {div_remainder, div_quotient};

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy       <= 1'b0;
         mul_start  <= 1'b0;
         div_start  <= 1'b0;
         resp_valid <= 1'b0;
         op_q       <= MDU_MUL;
      end
      else
      begin
         mul_start  <= accept & (req.op == MDU_MUL);
         div_start  <= accept & (req.op == MDU_DIV);
         resp_valid <= busy & unit_done;
         if (accept)
         begin
            busy <= 1'b1;
            op_q <= req.op;
         end
         else if (resp_valid)
         begin
            // busy covers the response cycle and drops after it.
            busy <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         opnd_a    <= req.a;
         opnd_b    <= req.b;
         is_signed <= req.is_signed;
      end
      if (busy & unit_done)
      begin
         resp.op    <= op_q;
         resp.value <= unit_value;
      end
   end

endmodule

// ==== mdu_sva.sv ====
/*
 * Protocol assertions on the dispatch of the multiply/divide unit.
 */
module mdu_sva
(
   input logic clk,
   input logic reset,
   input logic busy,
   input logic resp_valid,
   input logic mul_start,
   input logic div_start,
   input logic mul_done,
   input logic div_done
);

   mul_start_pulse: assert property (@(posedge clk) disable iff (reset)
      mul_start |=> !mul_start)
      else $error("mul_start is high for more than one cycle");

   div_start_pulse: assert property (@(posedge clk) disable iff (reset)
      div_start |=> !div_start)
      else $error("div_start is high for more than one cycle");

   one_start: assert property (@(posedge clk) disable iff (reset)
      !(mul_start && div_start))
      else $error("both start strobes are high");

   // a unit only runs between its start and its done.
   busy_while_running: assert property (@(posedge clk) disable iff (reset)
      (mul_start || div_start || mul_done || div_done) |-> busy)
      else $error("a unit is active while busy is low");

   resp_pulse: assert property (@(posedge clk) disable iff (reset)
      resp_valid |=> !resp_valid)
      else $error("resp_valid is high for more than one cycle");

endmodule

bind mdu_dispatch mdu_sva i_sva
(
   .clk        (clk),
   .reset      (reset),
   .busy       (busy),
   .resp_valid (resp_valid),
   .mul_start  (mul_start),
   .div_start  (div_start),
   .mul_done   (mul_done),
   .div_done   (div_done)
);

// ==== mdu_tb.sv ====
/*
 * Testbench of the multiply/divide unit.
 * Sends corner and seeded random requests, some while busy,
 * and closes with the counts kept by the checker.
 */
module mdu_tb;

   import mdu_arith_pkg::*;
   import mdu_types_pkg::*;

   localparam int SEED             = 20768;
   localparam int RESET_CYCLES     = 8;
   localparam int NUM_CORNERS      = 5;
   // both operations, signed and unsigned, every pair of corners.
   localparam int NUM_CORNER_TESTS = 4 * NUM_CORNERS * NUM_CORNERS;
   localparam int NUM_RANDOM_TESTS = 60;
   localparam int NUM_TESTS        = NUM_CORNER_TESTS + NUM_RANDOM_TESTS;
   localparam int TIMEOUT_CYCLES   = NUM_TESTS * 24 + 100;

   logic      clk;
   logic      reset;
   logic      req_valid;
   mdu_req_t  req;
   logic      busy;
   logic      resp_valid;
   mdu_resp_t resp;
   int        checked;
   int        errors;
   int        ignored;
   int        cycle_count;
   mdu_req_t  stim;

   logic [OPERAND_WIDTH-1:0] corners [NUM_CORNERS] =
      '{16'h0000, 16'h0001, 16'hffff, 16'h8000, 16'h7fff};

   mdu_top i_dut
   (
      .clk        (clk),
      .reset      (reset),
      .req_valid  (req_valid),
      .req        (req),
      .busy       (busy),
      .resp_valid (resp_valid),
      .resp       (resp)
   );

   mdu_checker i_checker
   (
      .clk        (clk),
      .reset      (reset),
      .req_valid  (req_valid),
      .req        (req),
      .busy       (busy),
      .resp_valid (resp_valid),
      .resp       (resp),
      .checked    (checked),
      .errors     (errors),
      .ignored    (ignored)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // called 1 time unit after an edge and returns 1 time unit after the accepting edge.
   task automatic send_request(input mdu_req_t r);
      logic free;
      req_valid = 1'b1;
      req       = r;
      free      = ~busy;
      while (!free)
      begin
         @(posedge clk);
         #1;
         free = ~busy;
      end
      @(posedge clk);
      #1;
      req_valid = 1'b0;
   endtask

   task automatic present_while_busy(input mdu_req_t r);
      req_valid = 1'b1;
      req       = r;
      repeat (3) @(posedge clk);
      #1;
      req_valid = 1'b0;
   endtask

   function automatic mdu_req_t random_request();
      mdu_req_t r;
      r.op        = ($urandom_range(0, 1) == 1) ? MDU_DIV : MDU_MUL;
      r.is_signed = 1'($urandom_range(0, 1));
      r.a         = OPERAND_WIDTH'($urandom);
      r.b         = OPERAND_WIDTH'($urandom);
      // now and then a small divisor that may be zero.
      if ($urandom_range(0, 7) == 0)
         r.b = OPERAND_WIDTH'($urandom_range(0, 7));
      return r;
   endfunction

   initial
   begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         cycle_count = cycle_count + 1;
      end
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("ERRORS FOUND");
      $finish;
   end

   initial
   begin
      reset     = 1'b1;
      req_valid = 1'b0;
      req       = '0;
      void'($urandom(SEED));
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      reset = 1'b0;
      for (int op_i = 0; op_i < 2; op_i++)
         for (int sign_i = 0; sign_i < 2; sign_i++)
            for (int a_i = 0; a_i < NUM_CORNERS; a_i++)
               for (int b_i = 0; b_i < NUM_CORNERS; b_i++)
               begin
                  stim.op        = (op_i == 1) ? MDU_DIV : MDU_MUL;
                  stim.is_signed = (sign_i == 1);
                  stim.a         = corners[a_i];
                  stim.b         = corners[b_i];
                  send_request(stim);
               end
      for (int k = 0; k < NUM_RANDOM_TESTS; k++)
      begin
         send_request(random_request());
         if (k % 10 == 5)
            present_while_busy(random_request());
      end
      while (checked < NUM_TESTS)
         @(posedge clk);
      $display("tests %0d, ignored request cycles %0d, errors %0d", checked, ignored, errors);
      if (errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

// ==== mdu_top.sv ====
/*
 * Multiply/divide unit top level.
 * Dispatch in front of the sequential multiplier and divider.
 */
module mdu_top
(
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     req_valid,
   input  mdu_types_pkg::mdu_req_t  req,
   output logic                     busy,
   output logic                     resp_valid,
   output mdu_types_pkg::mdu_resp_t resp
);

   import mdu_arith_pkg::*;

   logic                     mul_start;
   logic                     div_start;
   logic                     is_signed;
   logic [OPERAND_WIDTH-1:0] opnd_a;
   logic [OPERAND_WIDTH-1:0] opnd_b;
   logic                     mul_done;
   logic [RESULT_WIDTH-1:0]  mul_product;
   logic                     div_done;
   logic [OPERAND_WIDTH-1:0] div_quotient;
   logic [OPERAND_WIDTH-1:0] div_remainder;

   mdu_dispatch i_dispatch
   (
      .clk           (clk),
      .reset         (reset),
      .req_valid     (req_valid),
      .req           (req),
      .busy          (busy),
      .resp_valid    (resp_valid),
      .resp          (resp),
      .mul_start     (mul_start),
      .div_start     (div_start),
      .is_signed     (is_signed),
      .opnd_a        (opnd_a),
      .opnd_b        (opnd_b),
      .mul_done      (mul_done),
      .mul_product   (mul_product),
      .div_done      (div_done),
      .div_quotient  (div_quotient),
      .div_remainder (div_remainder)
   );

   // operand a is the multiplier and the dividend.
   mul_seq16 i_mul
   (
      .clk          (clk),
      .reset        (reset),
      .start        (mul_start),
      .is_signed    (is_signed),
      .multiplier   (opnd_a),
      .multiplicand (opnd_b),
      .done         (mul_done),
      .product      (mul_product)
   );

   div_seq16 i_div
   (
      .clk       (clk),
      .reset     (reset),
      .start     (div_start),
      .is_signed (is_signed),
      .dividend  (opnd_a),
      .divisor   (opnd_b),
      .done      (div_done),
      .quotient  (div_quotient),
      .remainder (div_remainder)
   );

endmodule

// ==== mdu_types_pkg.sv ====
/*
 * Request and response types of the multiply/divide unit.
 * An operation code selects multiply or divide; a divide result carries
 * the remainder in the upper half and the quotient in the lower half.
 */
package mdu_types_pkg;

   import mdu_arith_pkg::*;

   typedef enum logic
   {
      MDU_MUL = 1'b0,
      MDU_DIV = 1'b1
   } mdu_op_t;

   // a request is taken only when the unit is not busy.
   typedef struct packed
   {
      mdu_op_t                  op;
      logic                     is_signed;
      logic [OPERAND_WIDTH-1:0] a;
      logic [OPERAND_WIDTH-1:0] b;
   } mdu_req_t;

   // response tagged with the operation that produced it.
   typedef struct packed
   {
      mdu_op_t                 op;
      logic [RESULT_WIDTH-1:0] value;
   } mdu_resp_t;

endpackage

// ==== mul_seq16.sv ====
/*
 * Sequential 16x16 multiplier.
 * Shift-add on the operand magnitudes, one multiplier bit per cycle,
 * with the product sign restored in the last step before done.
 */
module mul_seq16
(
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    start,
   input  logic                                    is_signed,
   input  logic [mdu_arith_pkg::OPERAND_WIDTH-1:0] multiplier,
   input  logic [mdu_arith_pkg::OPERAND_WIDTH-1:0] multiplicand,
   output logic                                    done,
   output logic [mdu_arith_pkg::RESULT_WIDTH-1:0]  product
);

   import mdu_arith_pkg::*;

   unit_state_t              state;
   logic [STEP_WIDTH-1:0]    step;

   logic                     signed_q;
   logic [OPERAND_WIDTH-1:0] mplier_raw;
   logic [OPERAND_WIDTH-1:0] mcand_raw;
   logic [OPERAND_WIDTH-1:0] mplier_copy;
   logic [RESULT_WIDTH-1:0]  mcand_copy;
   logic [RESULT_WIDTH-1:0]  acc;
   logic                     negative_output;

   // done covers exactly the one cycle spent in the last state.
   assign done = (state == UNIT_LAST);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= UNIT_IDLE;
         step  <= '0;
      end
      else
      begin
         case (state)
            UNIT_IDLE:
            begin
               if (start)
               begin
                  state <= UNIT_RUNNING;
                  step  <= LOAD_STEP;
               end
            end
            UNIT_RUNNING:
            begin
               if (step == FINAL_STEP)
               begin
                  state <= UNIT_LAST;
               end
               step <= step + 1'b1;
            end
            default:
            begin
               state <= UNIT_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == UNIT_IDLE)
      begin
         if (start)
         begin
            mplier_raw <= multiplier;
            mcand_raw  <= multiplicand;
            signed_q   <= is_signed;
         end
      end
      else if (state == UNIT_RUNNING)
      begin
         if (step == LOAD_STEP)
         begin
            // a most negative operand still has a 16-bit magnitude.
            mplier_copy     <= magnitude(mplier_raw, signed_q);
            mcand_copy      <= {{OPERAND_WIDTH{1'b0}}, magnitude(mcand_raw, signed_q)};
            negative_output <= signed_q & (mplier_raw[OPERAND_WIDTH-1] ^
                                           mcand_raw[OPERAND_WIDTH-1]);
            acc             <= '0;
         end
         else if (step == FINAL_STEP)
         begin
            product <= negative_output ? -acc : acc;
         end
         else
         begin
            if (mplier_copy[0])
            begin
               acc <= acc + mcand_copy;
            end
            mplier_copy <= mplier_copy >> 1;
            mcand_copy  <= mcand_copy << 1;
         end
      end
   end

endmodule

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and pass only when the pass message is printed.
verilator --binary --assert -Wno-fatal --top-module mdu_tb -f compile.f || exit 1
sim_out=$(./obj_dir/Vmdu_tb)
echo "$sim_out"
echo "$sim_out" | grep -q "NO ERRORS" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
